// File: Makefile
TOP = ddc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: dv/ddc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ddc_tb;

  localparam real CORDIC_GAIN   = 1.64676;
  localparam int  SCALE         = 8192;  // half of unity gain
  localparam int  SETTLE        = 6;     // cic outputs before the DC value holds
  localparam int  TOLERANCE     = 3;
  localparam int  DRAIN_CYCLES  = 2 * ddc_pkg::PIPE_DEPTH + 16;
  localparam int  TOTAL_SAMPLES = 4 * 40 + 64 + 32 + 24 + 200;
  localparam int  MAX_RATE      = 4;
  localparam int  TIMEOUT       = TOTAL_SAMPLES * MAX_RATE + 2000;
  localparam int  A             = 12000;
  localparam int  B             = -7000;

  logic        clk;
  logic        reset;
  logic        i_clear;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [31:0] i_tdata;
  logic        i_tvalid;
  logic        i_tlast;
  logic        o_tready;
  logic [31:0] o_tdata;
  logic        o_tvalid;
  logic        o_tlast;
  logic        i_tready;

  logic [31:0] rng;
  logic        random_ready;
  string       test_name;
  int          mix_a;  // sample as the mixer sees it
  int          mix_b;
  int          skip;
  bit          nco_mode;
  int          nco_base;  // quarter turn of the first checked output
  int          out_count;
  int          last_count;
  int          last_index;
  int          errors;
  int          test_errors_start;
  int          tests_run;
  int          tests_failed;
  int          cycles;

  ddc #(.CIC_MAX_DECIM(255), .FIFO_DEPTH(16)) uut (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .i_tlast(i_tlast), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .o_tlast(o_tlast), .i_tready(i_tready));

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int round_real(input real x);
    if (x >= 0.0) begin
      return $rtoi(x + 0.5);
    end
    return -$rtoi(0.5 - x);
  endfunction

  // CORDIC gain, then scale over 2^14
  function automatic int expect_component(input int v);
    return round_real(CORDIC_GAIN * v * SCALE / 16384.0);
  endfunction

  function automatic bit near(input int got, input int want);
    return (got - want <= TOLERANCE) && (want - got <= TOLERANCE);
  endfunction

  // I cos - Q sin and I sin + Q cos at multiples of 90 degrees
  function automatic void rotate_quarter(input int a, input int b, input int quarter,
                                         output int ri, output int rq);
    case (quarter)
      0: begin
        ri = a;
        rq = b;
      end
      1: begin
        ri = -b;
        rq = a;
      end
      2: begin
        ri = -a;
        rq = -b;
      end
      default: begin
        ri = b;
        rq = -a;
      end
    endcase
  endfunction

  function automatic int find_quarter(input int got_i, input int got_q);
    int ri;
    int rq;
    for (int q = 0; q < 4; q++) begin
      rotate_quarter(mix_a, mix_b, q, ri, rq);
      if (near(got_i, expect_component(ri)) && near(got_q, expect_component(rq))) begin
        return q;
      end
    end
    return -1;
  endfunction

  task automatic check_beat(input logic [31:0] data, input logic last);
    int got_i;
    int got_q;
    int quarter;
    int rot_i;
    int rot_q;
    int want_i;
    int want_q;
    got_i = int'($signed(data[31:16]));
    got_q = int'($signed(data[15:0]));
    if (last) begin
      last_count++;
      last_index = out_count;
    end
    if (out_count >= skip) begin
      if (nco_mode && nco_base < 0) begin
        nco_base = find_quarter(got_i, got_q);
        assert (nco_base >= 0) else begin
          $display("%s: output %0d is no quarter turn of the input", test_name, out_count);
          errors++;
          nco_base = 0;
        end
      end
      quarter = nco_mode ? (nco_base + out_count - skip) % 4 : 0;
      rotate_quarter(mix_a, mix_b, quarter, rot_i, rot_q);
      want_i = expect_component(rot_i);
      want_q = expect_component(rot_q);
      assert (near(got_i, want_i) && near(got_q, want_q)) else begin
        $display("FAILED %s output %0d: expected I=%0d Q=%0d, actual I=%0d Q=%0d",
                 test_name, out_count, want_i, want_q, got_i, got_q);
        errors++;
      end
    end
    out_count++;
  endtask

  // ready is set and the beat sampled 2 ns after the edge
  always begin
    @(posedge clk);
    #2;
    rng = xorshift32(rng);
    i_tready = random_ready ? rng[7] : 1'b1;
    if (!reset && o_tvalid && i_tready) begin
      check_beat(o_tdata, o_tlast);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic set_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    idle(1);
    i_set_stb  = 1'b0;
  endtask

  task automatic clear_chain();
    i_clear = 1'b1;
    idle(1);
    i_clear = 1'b0;
    idle(4);  // lets a deferred rate land before data
  endtask

  task automatic send_samples(input int n, input int a, input int b, input bit last_on_final);
    for (int k = 0; k < n; k++) begin
      i_tdata  = {a[15:0], b[15:0]};
      i_tlast  = last_on_final && (k == n - 1);
      i_tvalid = 1'b1;
      while (!o_tready) begin
        idle(1);
      end
      idle(1);
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic begin_test(input string name, input int a, input int b, input int n_skip,
                            input bit nco);
    test_name         = name;
    mix_a             = a;
    mix_b             = b;
    skip              = n_skip;
    nco_mode          = nco;
    nco_base          = -1;
    out_count         = 0;
    last_count        = 0;
    last_index        = -1;
    test_errors_start = errors;
  endtask

  task automatic collect(input int n_out, input int n_in);
    int waited;
    waited = 0;
    while (out_count < n_out && waited < 4 * n_in + 200) begin
      idle(1);
      waited++;
    end
    idle(DRAIN_CYCLES);  // catches extra outputs
    assert (out_count == n_out) else begin
      $display("FAILED %s output count: expected %0d, actual %0d", test_name, n_out, out_count);
      errors++;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %s ok, %0d outputs", test_name, out_count);
    end else begin
      tests_failed++;
      $display("test %s has %0d errors", test_name, errors - test_errors_start);
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    i_clear      = 1'b0;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_tdata      = '0;
    i_tvalid     = 1'b0;
    i_tlast      = 1'b0;
    i_tready     = 1'b1;
    rng          = 32'h382bc3f9;
    random_ready = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    idle(2);

    set_reg(ddc_pkg::SR_SCALE, SCALE);
    set_reg(ddc_pkg::SR_FREQ, 32'd0);
    set_reg(ddc_pkg::SR_MUX, 32'd0);
    clear_chain();
    begin_test("dc_rate1", A, B, SETTLE, 1'b0);
    send_samples(40, A, B, 1'b0);
    collect(40, 40);
    finish_test();

    set_reg(ddc_pkg::SR_MUX, 32'd2);  // real mode
    clear_chain();
    begin_test("real_mode", A, 0, SETTLE, 1'b0);
    send_samples(40, A, B, 1'b0);
    collect(40, 40);
    finish_test();

    set_reg(ddc_pkg::SR_MUX, 32'd1);
    clear_chain();
    begin_test("swap", B, A, SETTLE, 1'b0);
    send_samples(40, A, B, 1'b0);
    collect(40, 40);
    finish_test();

    set_reg(ddc_pkg::SR_MUX, 32'd0);
    set_reg(ddc_pkg::SR_FREQ, 32'h4000_0000);  // quarter turn per sample
    clear_chain();
    begin_test("nco", A, 0, SETTLE, 1'b1);
    send_samples(40, A, 0, 1'b0);
    collect(40, 40);
    finish_test();

    set_reg(ddc_pkg::SR_FREQ, 32'd0);
    clear_chain();
    set_reg(ddc_pkg::SR_DECIM, 32'd4);
    idle(4);
    begin_test("decim_rate4", A, B, SETTLE, 1'b0);
    send_samples(64, A, B, 1'b0);
    collect(16, 64);
    finish_test();

    // rate 2 written mid-stream waits for the next clear
    begin_test("deferred_rate", A, B, 0, 1'b0);
    send_samples(8, A, B, 1'b0);
    set_reg(ddc_pkg::SR_DECIM, 32'd2);
    send_samples(24, A, B, 1'b0);
    collect(8, 32);
    finish_test();

    clear_chain();
    begin_test("tlast_rate2", A, B, SETTLE, 1'b0);
    send_samples(24, A, B, 1'b1);
    collect(12, 24);
    assert (last_count == 1) else begin
      $display("FAILED %s tlast count: expected 1, actual %0d", test_name, last_count);
      errors++;
    end
    assert (last_index == 11) else begin
      $display("FAILED %s tlast position: expected 11, actual %0d", test_name, last_index);
      errors++;
    end
    finish_test();

    clear_chain();
    set_reg(ddc_pkg::SR_DECIM, 32'd1);
    idle(4);
    random_ready = 1'b1;
    begin_test("backpressure", -15000, 9000, SETTLE, 1'b0);
    send_samples(200, -15000, 9000, 1'b0);
    collect(200, 200);
    random_ready = 1'b0;
    finish_test();

    $display("tests run %0d, with errors %0d, total errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/cic_decimator.sv
`timescale 1ns/1ns
`default_nettype none

module cic_decimator #(
  parameter int CIC_MAX_DECIM = 255
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_clear,
  input  ddc_pkg::iq_stage_t         i_stage,
  input  logic                       i_stb,
  input  logic [ddc_pkg::RATE_W-1:0] i_rate,
  input  logic                       i_rate_stb,
  output ddc_pkg::iq_stage_t         o_stage,
  output logic                       o_stb
);

  localparam int ORD     = ddc_pkg::CIC_ORDER;
  localparam int RW      = ddc_pkg::RATE_W;
  localparam int ACC_W   = ddc_pkg::SAMPLE_W + ORD * $clog2(CIC_MAX_DECIM + 1);  // full growth
  localparam int SHIFT_W = $clog2(ORD * RW + 1);

  logic signed [ACC_W-1:0] sample_in [2];  // index 0 is I, 1 is Q
  logic signed [ACC_W-1:0] integ [2][ORD];
  logic signed [ACC_W-1:0] comb_dly [2][ORD];
  logic signed [ACC_W-1:0] comb [2][ORD+1];
  logic signed [ACC_W-1:0] norm [2];
  logic [RW-1:0]           count;
  logic [SHIFT_W-1:0]      shift;
  logic                    dec_stb;
  logic                    dec_last;
  logic                    last_acc;  // last seen in the current group

  // DC gain is rate^ORD and is undone exactly for powers of two
  function automatic logic [SHIFT_W-1:0] norm_shift(input logic [RW-1:0] rate);
    logic [RW-1:0]      span;
    logic [SHIFT_W-1:0] bits;
    span = rate - 1'b1;
    bits = '0;
    for (int b = 0; b < RW; b++) begin
      if (span[b]) begin
        bits = SHIFT_W'(b + 1);
      end
    end
    return SHIFT_W'(ORD) * bits;
  endfunction

  assign shift        = norm_shift(i_rate);
  assign sample_in[0] = ACC_W'(i_stage.i);
  assign sample_in[1] = ACC_W'(i_stage.q);

  // comb result goes straight to the gain stage
  assign o_stage = '{i: norm[0][ddc_pkg::SAMPLE_W-1:0], q: norm[1][ddc_pkg::SAMPLE_W-1:0],
                     last: dec_last};
  assign o_stb   = dec_stb;

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      comb[c][0] = integ[c][ORD-1];
      for (int k = 0; k < ORD; k++) begin
        comb[c][k+1] = comb[c][k] - comb_dly[c][k];
      end
      norm[c] = comb[c][ORD] >>> shift;
    end
  end

  // integrators wrap; the combs recover the result modulo 2^ACC_W
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      for (int c = 0; c < 2; c++) begin
        for (int k = 0; k < ORD; k++) begin
          integ[c][k]    <= '0;
          comb_dly[c][k] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (i_stb) begin
          integ[c][0] <= integ[c][0] + sample_in[c];
          for (int k = 1; k < ORD; k++) begin
            integ[c][k] <= integ[c][k] + integ[c][k-1];
          end
        end
        if (dec_stb) begin
          for (int k = 0; k < ORD; k++) begin
            comb_dly[c][k] <= comb[c][k];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      count    <= '0;
      dec_stb  <= 1'b0;
      dec_last <= 1'b0;
      last_acc <= 1'b0;
    end else begin
      dec_stb <= 1'b0;
      if (i_rate_stb) begin
        count    <= '0;  // restart decimation phase
        last_acc <= 1'b0;
      end else if (i_stb) begin
        if (count >= i_rate - 1'b1) begin
          count    <= '0;
          dec_stb  <= 1'b1;
          dec_last <= last_acc | i_stage.last;
          last_acc <= 1'b0;
        end else begin
          count    <= count + 1'b1;
          last_acc <= last_acc | i_stage.last;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cordic_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_mixer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        i_clear,
  input  ddc_pkg::iq_stage_t          i_stage,
  input  logic                        i_stb,
  input  logic [ddc_pkg::ANGLE_W-1:0] i_phase,
  output ddc_pkg::iq_stage_t          o_stage,
  output logic                        o_stb
);

  localparam int N  = ddc_pkg::CORDIC_STAGES;
  localparam int CW = ddc_pkg::CORDIC_W;
  localparam int SW = ddc_pkg::SAMPLE_W;

  logic signed [CW-1:0]              xi;
  logic signed [CW-1:0]              yi;
  logic signed [CW-1:0]              x [N+1];
  logic signed [CW-1:0]              y [N+1];
  logic signed [ddc_pkg::ANGLE_W-1:0] z [N];  // residual angle
  logic [N:0]                        stb_pipe;
  logic [N:0]                        last_pipe;

  function automatic logic signed [SW-1:0] clip(input logic signed [CW-1:0] v);
    if (v[CW-1:SW-1] == {(CW-SW+1){v[CW-1]}}) begin
      return v[SW-1:0];
    end
    return v[CW-1] ? {1'b1, {(SW-1){1'b0}}} : {1'b0, {(SW-1){1'b1}}};
  endfunction

  assign xi = CW'(i_stage.i);
  assign yi = CW'(i_stage.q);

  // quadrant pre-rotation leaves less than 90 degrees for the iterations
  always_ff @(posedge clk) begin
    case (i_phase[ddc_pkg::ANGLE_W-1 -: 2])
      2'b00: begin
        x[0] <= xi;
        y[0] <= yi;
      end
      2'b01: begin
        x[0] <= -yi;
        y[0] <= xi;
      end
      2'b10: begin
        x[0] <= -xi;
        y[0] <= -yi;
      end
      default: begin
        x[0] <= yi;
        y[0] <= -xi;
      end
    endcase
    z[0] <= {2'b00, i_phase[ddc_pkg::ANGLE_W-3:0]};
  end

  for (genvar k = 0; k < N; k++) begin : g_iter
    always_ff @(posedge clk) begin
      if (z[k] >= 0) begin
        x[k+1] <= x[k] - (y[k] >>> k);
        y[k+1] <= y[k] + (x[k] >>> k);
      end else begin
        x[k+1] <= x[k] + (y[k] >>> k);
        y[k+1] <= y[k] - (x[k] >>> k);
      end
    end
    if (k < N - 1) begin : g_angle
      always_ff @(posedge clk) begin
        if (z[k] >= 0) begin
          z[k+1] <= z[k] - $signed(ddc_pkg::CORDIC_ANGLES[k]);
        end else begin
          z[k+1] <= z[k] + $signed(ddc_pkg::CORDIC_ANGLES[k]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    o_stage.i <= clip(x[N]);  // still carries the ~1.647 CORDIC gain
    o_stage.q <= clip(y[N]);
    if (reset || i_clear) begin
      stb_pipe     <= '0;
      last_pipe    <= '0;
      o_stb        <= 1'b0;
      o_stage.last <= 1'b0;
    end else begin
      stb_pipe     <= {stb_pipe[N-1:0], i_stb};
      last_pipe    <= {last_pipe[N-1:0], i_stage.last};
      o_stb        <= stb_pipe[N];
      o_stage.last <= last_pipe[N];
    end
  end

endmodule

`default_nettype wire

// File: source/ddc.sv
`timescale 1ns/1ns
`default_nettype none

module ddc #(
  parameter int CIC_MAX_DECIM = 255,
  parameter int FIFO_DEPTH    = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_clear,     // clears the chain, settings are kept
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [31:0] i_tdata,
  input  logic        i_tvalid,
  input  logic        i_tlast,
  output logic        o_tready,
  output logic [31:0] o_tdata,
  output logic        o_tvalid,
  output logic        o_tlast,
  input  logic        i_tready
);

  ddc_pkg::ddc_config_t        config_q;
  ddc_pkg::iq_stage_t          fe_stage;
  ddc_pkg::iq_stage_t          mix_stage;
  ddc_pkg::iq_stage_t          cic_stage;
  logic [ddc_pkg::ANGLE_W-1:0] fe_phase;
  logic [31:0]                 gain_data;
  logic                        accept;
  logic                        fe_stb;
  logic                        mix_stb;
  logic                        cic_stb;
  logic                        gain_stb;
  logic                        gain_last;

  assign accept = i_tvalid && o_tready;

  ddc_settings u_settings (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_sample_accepted(accept), .o_config(config_q));

  ddc_front_end u_front_end (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_accept(accept), .i_config(config_q),
    .o_stage(fe_stage), .o_stb(fe_stb), .o_phase(fe_phase));

  cordic_mixer u_mixer (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_stage(fe_stage), .i_stb(fe_stb), .i_phase(fe_phase),
    .o_stage(mix_stage), .o_stb(mix_stb));

  cic_decimator #(.CIC_MAX_DECIM(CIC_MAX_DECIM)) u_cic (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_stage(mix_stage), .i_stb(mix_stb),
    .i_rate(config_q.cic_rate), .i_rate_stb(config_q.rate_stb),
    .o_stage(cic_stage), .o_stb(cic_stb));

  gain_stage u_gain (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_stage(cic_stage), .i_stb(cic_stb), .i_scale(config_q.scale),
    .o_data(gain_data), .o_last(gain_last), .o_stb(gain_stb));

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_data(gain_data), .i_last(gain_last), .i_stb(gain_stb), .i_tready(i_tready),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
    .o_room(o_tready));  // input stalls while the fifo could overflow

endmodule

`default_nettype wire

// File: source/ddc_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module ddc_front_end (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_clear,
  input  logic [31:0]                  i_tdata,
  input  logic                         i_tlast,
  input  logic                         i_accept,
  input  ddc_pkg::ddc_config_t         i_config,
  output ddc_pkg::iq_stage_t           o_stage,
  output logic                         o_stb,
  output logic [ddc_pkg::ANGLE_W-1:0]  o_phase
);

  localparam int PAD_W = ddc_pkg::SAMPLE_W - ddc_pkg::OUT_W;

  logic signed [ddc_pkg::SAMPLE_W-1:0] in_i;
  logic signed [ddc_pkg::SAMPLE_W-1:0] in_q;
  logic [ddc_pkg::PHASE_W-1:0]         phase;

  assign in_i = {i_tdata[2*ddc_pkg::OUT_W-1:ddc_pkg::OUT_W], {PAD_W{1'b0}}};  // I in upper half
  assign in_q = {i_tdata[ddc_pkg::OUT_W-1:0], {PAD_W{1'b0}}};

  always_ff @(posedge clk) begin
    o_stage.i <= i_config.swap_iq ? in_q : in_i;
    if (i_config.real_mode) begin
      o_stage.q <= '0;  // real input, Q dropped after the swap
    end else begin
      o_stage.q <= i_config.swap_iq ? in_i : in_q;
    end
    if (reset || i_clear) begin
      o_stb        <= 1'b0;
      o_stage.last <= 1'b0;
    end else begin
      o_stb        <= i_accept;
      o_stage.last <= i_tlast;
    end
  end

  // NCO, steps after each sample leaves so o_phase matches o_stage
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      phase <= '0;
    end else if (o_stb) begin
      phase <= phase + i_config.phase_inc;
    end
  end

  assign o_phase = phase[ddc_pkg::PHASE_W-1 -: ddc_pkg::ANGLE_W];

endmodule

`default_nettype wire

// File: source/ddc_pkg.sv
`default_nettype none

package ddc_pkg;

  localparam int SAMPLE_W      = 24;  // internal sample width
  localparam int CORDIC_W      = 25;  // one guard bit for the rotation
  localparam int PHASE_W       = 32;
  localparam int ANGLE_W       = 24;  // top bits of the phase
  localparam int CORDIC_STAGES = 20;
  localparam int SCALE_W       = 18;
  localparam int OUT_W         = 16;
  localparam int RATE_W        = 8;
  localparam int CIC_ORDER     = 4;

  // upper bound on samples between input accept and fifo write
  localparam int PIPE_DEPTH = CORDIC_STAGES + 8;

  localparam logic [7:0] SR_FREQ  = 8'd0;
  localparam logic [7:0] SR_SCALE = 8'd1;
  localparam logic [7:0] SR_DECIM = 8'd2;
  localparam logic [7:0] SR_MUX   = 8'd3;

  // atan(2^-k), a full turn is 2^ANGLE_W
  localparam logic [ANGLE_W-1:0] CORDIC_ANGLES [CORDIC_STAGES] = '{
    24'd2097152, 24'd1238021, 24'd654136,  24'd332050,
    24'd166669,  24'd83416,   24'd41718,   24'd20860,
    24'd10430,   24'd5215,    24'd2608,    24'd1304,
    24'd652,     24'd326,     24'd163,     24'd81,
    24'd41,      24'd20,      24'd10,      24'd5
  };

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
    logic                       last;
  } iq_stage_t;

  typedef struct packed {
    logic [PHASE_W-1:0]        phase_inc;
    logic signed [SCALE_W-1:0] scale;
    logic [RATE_W-1:0]         cic_rate;   // applied rate, not the last one written
    logic                      swap_iq;
    logic                      real_mode;
    logic                      rate_stb;   // one cycle when cic_rate changes
  } ddc_config_t;

endpackage

`default_nettype wire

// File: source/ddc_settings.sv
`timescale 1ns/1ns
`default_nettype none

module ddc_settings (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  logic                 i_set_stb,
  input  logic [7:0]           i_set_addr,
  input  logic [31:0]          i_set_data,
  input  logic                 i_sample_accepted,
  output ddc_pkg::ddc_config_t o_config
);

  logic [ddc_pkg::RATE_W-1:0] rate_pend;  // last rate written
  logic                       rate_wr;    // rate register just written
  logic                       rate_hold;  // write arrived while chain busy
  logic                       active;     // samples accepted since clear

  always_ff @(posedge clk) begin
    if (reset) begin
      o_config          <= '0;
      o_config.cic_rate <= ddc_pkg::RATE_W'(1);  // no decimation
      rate_pend         <= ddc_pkg::RATE_W'(1);
      rate_wr           <= 1'b0;
      rate_hold         <= 1'b0;
      active            <= 1'b0;
    end else begin
      rate_wr <= 1'b0;
      if (i_set_stb) begin
        case (i_set_addr)
          ddc_pkg::SR_FREQ:  o_config.phase_inc <= i_set_data;
          ddc_pkg::SR_SCALE: o_config.scale <= i_set_data[ddc_pkg::SCALE_W-1:0];
          ddc_pkg::SR_DECIM: begin
            rate_pend <= i_set_data[ddc_pkg::RATE_W-1:0];
            rate_wr   <= 1'b1;
          end
          ddc_pkg::SR_MUX:   {o_config.real_mode, o_config.swap_iq} <= i_set_data[1:0];
          default: ;
        endcase
      end

      if (i_clear) begin
        active <= 1'b0;
      end else if (i_sample_accepted) begin
        active <= 1'b1;
      end

      // changing the CIC rate mid-stream would corrupt its state
      if (rate_wr && active) begin
        rate_hold <= 1'b1;
      end
      if ((i_clear || !active) && (rate_wr || rate_hold)) begin
        rate_hold         <= 1'b0;
        o_config.cic_rate <= rate_pend;
        o_config.rate_stb <= 1'b1;
      end else begin
        o_config.rate_stb <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/gain_stage.sv
`timescale 1ns/1ns
`default_nettype none

module gain_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_clear,
  input  ddc_pkg::iq_stage_t                 i_stage,
  input  logic                               i_stb,
  input  logic signed [ddc_pkg::SCALE_W-1:0] i_scale,
  output logic [31:0]                        o_data,
  output logic                               o_last,
  output logic                               o_stb
);

  localparam int SW       = ddc_pkg::SAMPLE_W;
  localparam int OW       = ddc_pkg::OUT_W;
  localparam int PROD_W   = SW + 1 + ddc_pkg::SCALE_W;  // 43 bit product
  localparam int KEEP_LSB = 14;                          // scale 2^14 is unity
  localparam int KEEP_W   = PROD_W - KEEP_LSB;

  logic signed [PROD_W-1:0] prod_i;
  logic signed [PROD_W-1:0] prod_q;
  logic signed [SW-1:0]     clip_i;
  logic signed [SW-1:0]     clip_q;
  logic [2:0]               stb_d;
  logic [2:0]               last_d;

  function automatic logic signed [SW-1:0] sat(input logic signed [KEEP_W-1:0] v);
    if (v[KEEP_W-1:SW-1] == {(KEEP_W-SW+1){v[KEEP_W-1]}}) begin
      return v[SW-1:0];
    end
    return v[KEEP_W-1] ? {1'b1, {(SW-1){1'b0}}} : {1'b0, {(SW-1){1'b1}}};
  endfunction

  // round half up, only the positive side can overflow
  function automatic logic [OW-1:0] round_sat(input logic signed [SW-1:0] v);
    logic signed [SW:0] s;
    s = {v[SW-1], v} + (SW+1)'(1 << (SW - OW - 1));
    if (s[SW] != s[SW-1]) begin
      return {1'b0, {(OW-1){1'b1}}};
    end
    return s[SW-1 -: OW];
  endfunction

  always_ff @(posedge clk) begin
    prod_i <= PROD_W'(i_stage.i) * PROD_W'(i_scale);
    prod_q <= PROD_W'(i_stage.q) * PROD_W'(i_scale);
    clip_i <= sat(prod_i[PROD_W-1:KEEP_LSB]);
    clip_q <= sat(prod_q[PROD_W-1:KEEP_LSB]);
    o_data <= {round_sat(clip_i), round_sat(clip_q)};  // I above Q
    if (reset || i_clear) begin
      stb_d  <= '0;
      last_d <= '0;
    end else begin
      stb_d  <= {stb_d[1:0], i_stb};
      last_d <= {last_d[1:0], i_stage.last};
    end
  end

  assign o_stb  = stb_d[2];
  assign o_last = last_d[2];

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_clear,
  input  logic [31:0] i_data,
  input  logic        i_last,
  input  logic        i_stb,
  input  logic        i_tready,
  output logic [31:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  output logic        o_room
);

  // extra entries absorb whatever is still in the pipeline
  localparam int ENTRIES = FIFO_DEPTH + ddc_pkg::PIPE_DEPTH;
  localparam int PTR_W   = $clog2(ENTRIES);
  localparam int CNT_W   = $clog2(ENTRIES + 1);

  logic [32:0]      mem [ENTRIES];  // {last, data}
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(ENTRIES - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop      = o_tvalid && i_tready;
  assign o_tvalid = (count != '0);
  assign o_tdata  = mem[rd_ptr][31:0];
  assign o_tlast  = o_tvalid && mem[rd_ptr][32];
  assign o_room   = (CNT_W'(ENTRIES) - count) >= CNT_W'(ddc_pkg::PIPE_DEPTH);

  always_ff @(posedge clk) begin
    if (i_stb) begin
      mem[wr_ptr] <= {i_last, i_data};
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_stb) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_stb, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
source/ddc_pkg.sv
source/ddc_settings.sv
source/ddc_front_end.sv
source/cordic_mixer.sv
source/cic_decimator.sv
source/gain_stage.sv
source/sample_fifo.sv
source/ddc.sv
dv/ddc_tb.sv
